// ==== common/keypad_pkg.sv ====
`default_nettype none

package keypad_pkg;

	// bus word width
	localparam int DATA_W = 16;

	// scan timing, in clocks and whole scans
	localparam int SCAN_HOLD      = 4;
	localparam int DEBOUNCE_SCANS = 3;
	localparam int HOLD_W         = $clog2(SCAN_HOLD);
	localparam int DEB_W          = $clog2(DEBOUNCE_SCANS + 1);

	// event queue
	localparam int FIFO_DEPTH = 8;
	localparam int FIFO_AW    = 3;

	// register word addresses
	localparam logic [1:0] REG_STATUS = 2'd0;
	localparam logic [1:0] REG_DATA   = 2'd1;
	localparam logic [1:0] REG_CTRL   = 2'd2;

	// STATUS fields
	localparam int ST_CNT_LSB = 0;  // count in 3:0
	localparam int ST_EMPTY   = 4;
	localparam int ST_FULL    = 5;
	localparam int ST_OVF     = 6;  // write 1 to clear

	// CTRL fields
	localparam int CTRL_EN     = 0;
	localparam int CTRL_IRQ_EN = 1;

	// strobed column and sampled rows, both one-hot
	typedef struct packed {
		logic [3:0] col;
		logic [3:0] row;
	} key_code_t;

	// one queued key press, one data word wide
	typedef struct packed {
		key_code_t  code;
		logic [7:0] char;  // ascii
	} key_event_t;

	typedef struct packed {
		logic              cyc;
		logic              stb;
		logic              we;
		logic [1:0]        adr;  // word address
		logic [DATA_W-1:0] dat;
	} wb_req_t;

	typedef struct packed {
		logic              ack;
		logic [DATA_W-1:0] dat;
	} wb_rsp_t;

endpackage

`default_nettype wire

// ==== keypad/keypad_scan.sv ====
`timescale 1ns/10ps
`default_nettype none

module keypad_scan (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  enable,
	input  logic [3:0]            read_row,
	output logic [3:0]            scan_col,
	output logic                  press_valid,
	output keypad_pkg::key_code_t press_code
);
	import keypad_pkg::*;

	logic [HOLD_W-1:0] hold_cnt;
	logic [1:0]        col_idx;
	logic              sample;
	logic              scan_end;
	logic              row_onehot;
	logic              seen;   // a key column was found this scan
	logic              ghost;  // scan already spoilt
	key_code_t         cand;
	logic              cur_seen;
	logic              cur_ghost;
	key_code_t         cur_cand;
	logic              key_ok;
	key_code_t         prev_code;
	logic [DEB_W-1:0]  stable_cnt;
	logic [DEB_W-1:0]  stable_nxt;
	logic [DEB_W-1:0]  empty_cnt;
	logic              armed;

	assign scan_col   = 4'b0001 << col_idx;
	assign sample     = (hold_cnt == HOLD_W'(SCAN_HOLD - 1));  // last clock of hold
	assign scan_end   = sample && (col_idx == 2'd3);
	assign row_onehot = (read_row & (read_row - 4'd1)) == 4'b0000;

	// scan-wide result including the sample taken this clock
	always_comb begin
		cur_seen  = seen;
		cur_ghost = ghost;
		cur_cand  = cand;
		if (sample && read_row != 4'b0000) begin
			if (seen || !row_onehot) begin
				cur_ghost = 1'b1;  // second column or several rows
			end else begin
				cur_seen     = 1'b1;
				cur_cand.col = scan_col;
				cur_cand.row = read_row;
			end
		end
		key_ok = cur_seen && !cur_ghost;
	end

	// consecutive scans showing the same key, saturating
	always_comb begin
		if (!key_ok)
			stable_nxt = '0;
		else if (stable_cnt == '0 || cur_cand != prev_code)
			stable_nxt = DEB_W'(1);
		else if (stable_cnt != DEB_W'(DEBOUNCE_SCANS))
			stable_nxt = stable_cnt + 1'b1;
		else
			stable_nxt = stable_cnt;
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			hold_cnt <= '0;
			col_idx  <= '0;
			seen     <= 1'b0;
			ghost    <= 1'b0;
		end else begin
			hold_cnt <= sample ? '0 : hold_cnt + 1'b1;
			if (sample)
				col_idx <= col_idx + 1'b1;
			seen  <= scan_end ? 1'b0 : cur_seen;
			ghost <= scan_end ? 1'b0 : cur_ghost;
		end
	end

	always_ff @(posedge clk) begin
		cand <= cur_cand;
		if (scan_end && key_ok)
			prev_code <= cur_cand;
		if (scan_end)
			press_code <= cur_cand;
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			stable_cnt  <= '0;
			empty_cnt   <= '0;
			armed       <= 1'b1;
			press_valid <= 1'b0;
		end else begin
			press_valid <= 1'b0;
			if (!enable) begin
				stable_cnt <= '0;
				empty_cnt  <= '0;
				armed      <= 1'b1;
			end else if (scan_end) begin
				stable_cnt <= stable_nxt;
				if (key_ok) begin
					empty_cnt <= '0;
					if (armed && stable_nxt == DEB_W'(DEBOUNCE_SCANS)) begin
						press_valid <= 1'b1;  // once per press
						armed       <= 1'b0;
					end
				end else begin
					if (empty_cnt != DEB_W'(DEBOUNCE_SCANS))
						empty_cnt <= empty_cnt + 1'b1;
					if (empty_cnt >= DEB_W'(DEBOUNCE_SCANS - 1))
						armed <= 1'b1;  // released long enough
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== keypad/key_decode.sv ====
`timescale 1ns/10ps
`default_nettype none

module key_decode (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   press_valid,
	input  keypad_pkg::key_code_t  press_code,
	output logic                   ev_valid,
	output keypad_pkg::key_event_t ev
);

	always_ff @(posedge clk or negedge rst) begin
		if (!rst)
			ev_valid <= 1'b0;
		else
			ev_valid <= press_valid;
	end

	// row picks the layout line and column the position in it
	always_ff @(posedge clk) begin
		if (press_valid) begin
			ev.code <= press_code;
			case ({press_code.row, press_code.col})
				8'b0001_0001: ev.char <= "1";
				8'b0001_0010: ev.char <= "2";
				8'b0001_0100: ev.char <= "3";
				8'b0001_1000: ev.char <= "A";
				8'b0010_0001: ev.char <= "4";
				8'b0010_0010: ev.char <= "5";
				8'b0010_0100: ev.char <= "6";
				8'b0010_1000: ev.char <= "B";
				8'b0100_0001: ev.char <= "7";
				8'b0100_0010: ev.char <= "8";
				8'b0100_0100: ev.char <= "9";
				8'b0100_1000: ev.char <= "C";
				8'b1000_0001: ev.char <= "*";
				8'b1000_0010: ev.char <= "0";
				8'b1000_0100: ev.char <= "#";
				8'b1000_1000: ev.char <= "D";
				default:      ev.char <= 8'h00;  // not reachable from the scanner
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== src/key_fifo.sv ====
`timescale 1ns/10ps
`default_nettype none

module key_fifo (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   push,
	input  keypad_pkg::key_event_t push_ev,
	input  logic                   pop,
	input  logic                   ovf_clr,
	output keypad_pkg::key_event_t head,
	output logic [3:0]             count,
	output logic                   empty,
	output logic                   full,
	output logic                   overflow
);
	import keypad_pkg::*;

	key_event_t         mem [FIFO_DEPTH];
	logic [FIFO_AW-1:0] wr_ptr;
	logic [FIFO_AW-1:0] rd_ptr;
	logic               do_push;
	logic               do_pop;

	assign empty   = (count == 4'd0);
	assign full    = (count == 4'(FIFO_DEPTH));
	assign do_push = push && !full;  // full check ignores a same-clock pop
	assign do_pop  = pop && !empty;
	assign head    = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (do_push)
			mem[wr_ptr] <= push_ev;
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;  // depth is a power of two
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10:   count <= count + 4'd1;
				2'b01:   count <= count - 4'd1;
				default: count <= count;
			endcase
		end
	end

	// sticky until cleared, a new drop wins over the clear
	always_ff @(posedge clk or negedge rst) begin
		if (!rst)
			overflow <= 1'b0;
		else if (push && full)
			overflow <= 1'b1;
		else if (ovf_clr)
			overflow <= 1'b0;
	end

endmodule

`default_nettype wire

// ==== src/keypad_wb.sv ====
`timescale 1ns/10ps
`default_nettype none

module keypad_wb (
	input  logic                   clk,
	input  logic                   rst,
	input  keypad_pkg::wb_req_t    bus_req,
	output keypad_pkg::wb_rsp_t    bus_rsp,
	input  keypad_pkg::key_event_t head,
	input  logic [3:0]             count,
	input  logic                   empty,
	input  logic                   full,
	input  logic                   overflow,
	output logic                   pop,
	output logic                   ovf_clr,
	output logic                   enable,
	output logic                   irq
);
	import keypad_pkg::*;

	logic              ack;
	logic              req;
	logic              wr;
	logic              rd;
	logic              irq_en;
	logic [DATA_W-1:0] status_word;
	logic [DATA_W-1:0] ctrl_word;
	logic [DATA_W-1:0] rd_mux;
	logic [DATA_W-1:0] rd_dat;

	// no new request in the ack clock, so ack is a single pulse
	assign req = bus_req.cyc && bus_req.stb && !ack;
	assign wr  = req && bus_req.we;
	assign rd  = req && !bus_req.we;

	assign bus_rsp.ack = ack;
	assign bus_rsp.dat = rd_dat;

	always_comb begin
		status_word                   = '0;
		status_word[ST_CNT_LSB +: 4]  = count;
		status_word[ST_EMPTY]         = empty;
		status_word[ST_FULL]          = full;
		status_word[ST_OVF]           = overflow;
		ctrl_word                     = '0;
		ctrl_word[CTRL_EN]            = enable;
		ctrl_word[CTRL_IRQ_EN]        = irq_en;
		case (bus_req.adr)
			REG_STATUS: rd_mux = status_word;
			REG_DATA:   rd_mux = empty ? '0 : head;
			REG_CTRL:   rd_mux = ctrl_word;
			default:    rd_mux = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rd)
			rd_dat <= rd_mux;
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			ack     <= 1'b0;
			pop     <= 1'b0;
			ovf_clr <= 1'b0;
			enable  <= 1'b0;
			irq_en  <= 1'b0;
			irq     <= 1'b0;
		end else begin
			ack     <= req;
			pop     <= rd && bus_req.adr == REG_DATA && !empty;  // lines up with ack
			ovf_clr <= wr && bus_req.adr == REG_STATUS && bus_req.dat[ST_OVF];
			if (wr && bus_req.adr == REG_CTRL) begin
				enable <= bus_req.dat[CTRL_EN];
				irq_en <= bus_req.dat[CTRL_IRQ_EN];
			end
			irq <= irq_en && !empty;  // one clock behind the FIFO
		end
	end

endmodule

`default_nettype wire

// ==== src/keypad_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module keypad_top (
	input  logic                clk,
	input  logic                rst,
	input  logic [3:0]          read_row,
	output logic [3:0]          scan_col,
	input  keypad_pkg::wb_req_t bus_req,
	output keypad_pkg::wb_rsp_t bus_rsp,
	output logic                irq
);
	import keypad_pkg::*;

	logic       enable;
	logic       press_valid;
	key_code_t  press_code;
	logic       ev_valid;
	key_event_t ev;
	key_event_t head;
	logic [3:0] count;
	logic       empty;
	logic       full;
	logic       overflow;
	logic       pop;
	logic       ovf_clr;

	keypad_scan scan0 (
		.clk         (clk),
		.rst         (rst),
		.enable      (enable),
		.read_row    (read_row),
		.scan_col    (scan_col),
		.press_valid (press_valid),
		.press_code  (press_code)
	);

	key_decode decode0 (
		.clk         (clk),
		.rst         (rst),
		.press_valid (press_valid),
		.press_code  (press_code),
		.ev_valid    (ev_valid),
		.ev          (ev)
	);

	key_fifo fifo0 (
		.clk      (clk),
		.rst      (rst),
		.push     (ev_valid),
		.push_ev  (ev),
		.pop      (pop),
		.ovf_clr  (ovf_clr),
		.head     (head),
		.count    (count),
		.empty    (empty),
		.full     (full),
		.overflow (overflow)
	);

	keypad_wb wb0 (
		.clk      (clk),
		.rst      (rst),
		.bus_req  (bus_req),
		.bus_rsp  (bus_rsp),
		.head     (head),
		.count    (count),
		.empty    (empty),
		.full     (full),
		.overflow (overflow),
		.pop      (pop),
		.ovf_clr  (ovf_clr),
		.enable   (enable),
		.irq      (irq)
	);

endmodule

`default_nettype wire

// ==== testbench/keypad_assert.sv ====
`timescale 1ns/10ps
`default_nettype none

module keypad_assert (
	input logic                clk,
	input logic                rst,
	input keypad_pkg::wb_req_t bus_req,
	input keypad_pkg::wb_rsp_t bus_rsp,
	input logic [3:0]          scan_col,
	input logic                irq,
	input logic                empty
);

	ack_in_cycle: assert property (@(posedge clk) disable iff (!rst)
		bus_rsp.ack |-> bus_req.cyc && bus_req.stb)
		else $error("ack outside a bus cycle");

	// one request, one ack
	ack_single: assert property (@(posedge clk) disable iff (!rst)
		bus_rsp.ack |=> !bus_rsp.ack)
		else $error("ack high on two clocks in a row");

	col_onehot: assert property (@(posedge clk) disable iff (!rst)
		$onehot(scan_col))
		else $error("column strobe not one-hot");

	// irq is registered, so look one clock back
	irq_pending: assert property (@(posedge clk) disable iff (!rst)
		irq |-> $past(!empty))
		else $error("irq with no queued event");

endmodule

bind keypad_top keypad_assert assert0 (
	.clk      (clk),
	.rst      (rst),
	.bus_req  (bus_req),
	.bus_rsp  (bus_rsp),
	.scan_col (scan_col),
	.irq      (irq),
	.empty    (empty)
);

`default_nettype wire

// ==== testbench/tb_keypad.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_keypad;
	import keypad_pkg::*;

	localparam int SCAN           = 4 * SCAN_HOLD;  // clocks per full scan
	localparam int TIMEOUT_CYCLES = 20000;

	logic        clk;
	logic        rst;
	logic [3:0]  read_row;
	logic [3:0]  scan_col;
	wb_req_t     bus_req;
	wb_rsp_t     bus_rsp;
	logic        irq;
	logic [15:0] held;      // one bit per key at col*4+row
	logic [31:0] lfsr;
	logic [15:0] expect_q[$];
	logic        model_ovf;
	int          cycles;

	keypad_top dut0 (
		.clk      (clk),
		.rst      (rst),
		.read_row (read_row),
		.scan_col (scan_col),
		.bus_req  (bus_req),
		.bus_rsp  (bus_rsp),
		.irq      (irq)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// fibonacci lfsr with taps 32 22 2 1
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		logic        fb;
		r = '0;
		for (int i = 0; i < n; i++) begin
			fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			r    = {r[30:0], fb};
		end
		return r;
	endfunction

	function automatic logic [3:0] col_rows(input logic [15:0] keys, input logic [3:0] col);
		logic [3:0] rows;
		rows = '0;
		for (int c = 0; c < 4; c++) begin
			if (col[c])
				rows = rows | keys[c*4 +: 4];
		end
		return rows;
	endfunction

	function automatic logic [15:0] key_bit(input int c, input int r);
		return 16'd1 << (c * 4 + r);
	endfunction

	// {col, row, ascii} for the 4x4 layout
	function automatic logic [15:0] key_word(input int c, input int r);
		string      layout;
		logic [3:0] col;
		logic [3:0] row;
		layout = "123A456B789C*0#D";
		col    = 4'b0001 << c;
		row    = 4'b0001 << r;
		return {col, row, layout[r*4+c]};
	endfunction

	function automatic logic [15:0] model_status();
		logic [15:0] st;
		st    = '0;
		st[3:0] = 4'(expect_q.size());
		st[4] = (expect_q.size() == 0);
		st[5] = (expect_q.size() == FIFO_DEPTH);
		st[6] = model_ovf;
		return st;
	endfunction

	// keypad follows the strobe one clock behind
	always @(posedge clk)
		read_row <= col_rows(held, scan_col);

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Test FAILED");
			$fatal(1);
		end
	end

	task automatic check(input logic [15:0] expected, input logic [15:0] actual,
			input string what);
		if (expected !== actual) begin
			$display("Fail at %0t: %s, expected %h got %h", $time, what, expected, actual);
			$display("Test FAILED");
			$fatal(1);
		end
	endtask

	task automatic bus_write(input logic [1:0] addr, input logic [15:0] wdata);
		@(posedge clk);
		bus_req.cyc <= 1'b1;
		bus_req.stb <= 1'b1;
		bus_req.we  <= 1'b1;
		bus_req.adr <= addr;
		bus_req.dat <= wdata;
		@(posedge clk);
		while (bus_rsp.ack !== 1'b1)
			@(posedge clk);
		bus_req.cyc <= 1'b0;
		bus_req.stb <= 1'b0;
		bus_req.we  <= 1'b0;
	endtask

	task automatic bus_read(input logic [1:0] addr, output logic [15:0] rdata);
		@(posedge clk);
		bus_req.cyc <= 1'b1;
		bus_req.stb <= 1'b1;
		bus_req.we  <= 1'b0;
		bus_req.adr <= addr;
		bus_req.dat <= '0;
		@(posedge clk);
		while (bus_rsp.ack !== 1'b1)
			@(posedge clk);
		rdata = bus_rsp.dat;
		bus_req.cyc <= 1'b0;
		bus_req.stb <= 1'b0;
	endtask

	task automatic press_keys(input logic [15:0] keys, input int hold_clks, input int rel_clks);
		@(posedge clk);
		held <= keys;
		repeat (hold_clks) @(posedge clk);
		held <= '0;
		repeat (rel_clks) @(posedge clk);
	endtask

	// depth-8 queue that drops on full
	task automatic model_push(input int c, input int r);
		if (expect_q.size() < FIFO_DEPTH)
			expect_q.push_back(key_word(c, r));
		else
			model_ovf = 1'b1;
	endtask

	task automatic check_status();
		logic [15:0] got;
		bus_read(REG_STATUS, got);
		check(model_status(), got, "STATUS read");
	endtask

	task automatic check_data();
		logic [15:0] got;
		logic [15:0] want;
		if (expect_q.size() == 0)
			want = 16'h0000;
		else
			want = expect_q.pop_front();
		bus_read(REG_DATA, got);
		check(want, got, "DATA read");
	endtask

	task automatic check_ctrl(input logic [15:0] want);
		logic [15:0] got;
		bus_read(REG_CTRL, got);
		check(want, got, "CTRL read");
	endtask

	task automatic random_press(input int min_scans);
		int c;
		int r;
		int hold;
		c    = int'(rand_bits(2));
		r    = int'(rand_bits(2));
		hold = min_scans + int'(rand_bits(3) % 5);
		press_keys(key_bit(c, r), hold * SCAN, 6 * SCAN);
		model_push(c, r);
	endtask

	initial begin
		int c;
		int r;
		int r2;
		int n;
		lfsr      = 32'h719c;
		held      = '0;
		model_ovf = 1'b0;
		cycles    = 0;
		rst       = 1'b0;
		read_row  = '0;
		bus_req   = '0;
		repeat (10) @(posedge clk);
		check(16'h0001, 16'(scan_col), "scan_col in reset");
		rst <= 1'b1;

		// reset values
		check_status();
		check_ctrl(16'h0000);
		check(16'h0000, 16'(irq), "irq after reset");

		// every key once
		bus_write(REG_CTRL, 16'h0001);
		for (int k = 0; k < 16; k++) begin
			c = k / 4;
			r = k % 4;
			press_keys(key_bit(c, r), (4 + int'(rand_bits(3) % 5)) * SCAN, 6 * SCAN);
			model_push(c, r);
			check_data();
			check_status();
		end

		// short press, ghost pair, disabled scanner
		press_keys(key_bit(int'(rand_bits(2)), int'(rand_bits(2))), SCAN, 6 * SCAN);
		check_status();
		c  = int'(rand_bits(2));
		r  = int'(rand_bits(2));
		r2 = (r + 1 + int'(rand_bits(2) % 3)) % 4;
		press_keys(key_bit(c, r) | key_bit(c, r2), 6 * SCAN, 6 * SCAN);
		check_status();
		bus_write(REG_CTRL, 16'h0000);
		for (int k = 0; k < 2; k++)
			press_keys(key_bit(int'(rand_bits(2)), int'(rand_bits(2))), 6 * SCAN, 6 * SCAN);
		check_status();
		bus_write(REG_CTRL, 16'h0001);

		// ten presses into a depth-8 queue
		for (int k = 0; k < 10; k++)
			random_press(4);
		check_status();
		for (int k = 0; k < 9; k++)
			check_data();
		bus_write(REG_STATUS, 16'h0040);
		model_ovf = 1'b0;
		check_status();

		// interrupt on and off
		bus_write(REG_CTRL, 16'h0003);
		check_ctrl(16'h0003);
		check(16'h0000, 16'(irq), "irq with empty queue");
		random_press(4);
		check(16'h0001, 16'(irq), "irq with event pending");
		check_data();
		repeat (2) @(posedge clk);
		check(16'h0000, 16'(irq), "irq after last read");
		bus_write(REG_CTRL, 16'h0001);
		random_press(4);
		check(16'h0000, 16'(irq), "irq while masked");
		check_data();

		// presses mixed with random reads
		for (int i = 0; i < 12; i++) begin
			random_press(4);
			n = int'(rand_bits(2));
			for (int j = 0; j < n; j++) begin
				repeat (int'(rand_bits(3))) @(posedge clk);
				if (rand_bits(1) == 32'd1)
					check_status();
				else
					check_data();
			end
		end
		while (expect_q.size() > 0)
			check_data();
		check_status();

		$display("Test OK");
		$finish;
	end

endmodule

`default_nettype wire

// ==== tb.f ====
common/keypad_pkg.sv
keypad/keypad_scan.sv
keypad/key_decode.sv
src/key_fifo.sv
src/keypad_wb.sv
src/keypad_top.sv
testbench/keypad_assert.sv
testbench/tb_keypad.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_keypad
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
JOBS      ?= 4
VFLAGS    ?= --binary --timing --assert -j $(JOBS)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR JOBS VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
